/* source/boot_defs.svh */
`ifndef BOOT_DEFS_SVH
`define BOOT_DEFS_SVH

// Bus widths
`define BOOT_ADDR_W      16
`define BOOT_DATA_W      32

// Word memory size
`define BOOT_MEM_WORDS   64
`define BOOT_MEM_IDX_W   6

// Host block sits above the memory in the address map
`define BOOT_HOST_BIT    15

// Host register byte offsets
`define BOOT_FREEZE_OFS  0
`define BOOT_FINISH_OFS  4

`endif

/* source/boot_pkg.sv */
`default_nettype none

`include "boot_defs.svh"

package boot_pkg;

   typedef logic [`BOOT_ADDR_W-1:0]    addr_t;
   typedef logic [`BOOT_DATA_W-1:0]    data_t;
   typedef logic [`BOOT_MEM_IDX_W-1:0] mem_idx_t;

   typedef enum logic [1:0] {
      NBF_WRITE,
      NBF_READ,
      NBF_FINISH
   } nbf_op_e;

   // One boot record from the stream
   typedef struct packed {
      nbf_op_e op;
      addr_t   addr;
      data_t   data;
   } nbf_rec_t;

   typedef struct packed {
      logic  psel;
      logic  penable;
      logic  pwrite;
      addr_t paddr;
      data_t pwdata;
   } apb_req_t;

   typedef struct packed {
      logic  pready;
      data_t prdata;
   } apb_rsp_t;

   typedef enum logic [1:0] {
      CFG_ZERO,
      CFG_UNFREEZE,
      CFG_DONE
   } cfg_state_e;

   typedef enum logic [1:0] {
      NBF_IDLE,
      NBF_SETUP,
      NBF_ACCESS,
      NBF_DONE
   } nbf_state_e;

endpackage

`default_nettype wire

/* source/cfg_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "boot_defs.svh"

module cfg_loader
   import boot_pkg::*;
(
   input  logic     clk_i,
   input  logic     arst_n_i,
   output apb_req_t apb_o,
   input  apb_rsp_t apb_i,
   output logic     done_o
);

   localparam addr_t freeze_addr = addr_t'((1 << `BOOT_HOST_BIT) + `BOOT_FREEZE_OFS);
   localparam mem_idx_t last_idx = mem_idx_t'(`BOOT_MEM_WORDS - 1);

   cfg_state_e state_q;
   mem_idx_t   idx_q;
   logic       access_q;

   // Every transfer is a write of zero
   always_comb
   begin
      apb_o.psel    = (state_q != CFG_DONE);
      apb_o.penable = access_q;
      apb_o.pwrite  = 1'b1;
      apb_o.pwdata  = '0;
      if (state_q == CFG_ZERO)
         apb_o.paddr = addr_t'({idx_q, 2'b00});
      else
         apb_o.paddr = freeze_addr;
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q  <= CFG_ZERO;
         idx_q    <= '0;
         access_q <= 1'b0;
      end
      else if (state_q != CFG_DONE)
      begin
         if (!access_q)
            access_q <= 1'b1;
         else if (apb_i.pready)
         begin
            // Next transfer starts with its setup cycle
            access_q <= 1'b0;
            if (state_q == CFG_ZERO)
            begin
               idx_q <= idx_q + mem_idx_t'(1);
               if (idx_q == last_idx)
                  state_q <= CFG_UNFREEZE;
            end
            else
               state_q <= CFG_DONE;
         end
      end
   end

   assign done_o = (state_q == CFG_DONE);

endmodule

`default_nettype wire

/* source/nbf_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "boot_defs.svh"

module nbf_loader
   import boot_pkg::*;
(
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  logic     enable_i,
   input  nbf_rec_t rec_i,
   input  logic     rec_valid_i,
   output logic     rec_ready_o,
   output apb_req_t apb_o,
   input  apb_rsp_t apb_i,
   output data_t    rsp_data_o,
   output logic     rsp_valid_o
);

   localparam addr_t finish_addr = addr_t'((1 << `BOOT_HOST_BIT) + `BOOT_FINISH_OFS);

   nbf_state_e state_q;
   nbf_rec_t   rec_q;
   data_t      rsp_data_q;
   logic       rsp_valid_q;
   logic       rec_take;
   logic       xfer_done;
   logic       is_read;
   logic       is_finish;

   assign rec_ready_o = (state_q == NBF_IDLE) && enable_i;
   assign rec_take    = rec_valid_i && rec_ready_o;
   assign xfer_done   = (state_q == NBF_ACCESS) && apb_i.pready;
   assign is_read     = (rec_q.op == NBF_READ);
   assign is_finish   = (rec_q.op == NBF_FINISH);

   // Finish record becomes a write of 1 to the host finish flag
   always_comb
   begin
      apb_o.psel    = (state_q == NBF_SETUP) || (state_q == NBF_ACCESS);
      apb_o.penable = (state_q == NBF_ACCESS);
      apb_o.pwrite  = !is_read;
      apb_o.paddr   = is_finish ? finish_addr : rec_q.addr;
      apb_o.pwdata  = is_finish ? data_t'(1) : rec_q.data;
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q     <= NBF_IDLE;
         rsp_valid_q <= 1'b0;
      end
      else
      begin
         rsp_valid_q <= xfer_done && is_read;
         case (state_q)
            NBF_IDLE:
               if (rec_take)
                  state_q <= NBF_SETUP;
            NBF_SETUP:
               state_q <= NBF_ACCESS;
            NBF_ACCESS:
               if (apb_i.pready)
                  state_q <= is_finish ? NBF_DONE : NBF_IDLE;
            default:
               state_q <= NBF_DONE;
         endcase
      end
   end

   // Record and read data registers
   always_ff @(posedge clk_i)
   begin
      if (rec_take)
         rec_q <= rec_i;
      if (xfer_done && is_read)
         rsp_data_q <= apb_i.prdata;
   end

   assign rsp_data_o  = rsp_data_q;
   assign rsp_valid_o = rsp_valid_q;

endmodule

`default_nettype wire

/* source/apb_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "boot_defs.svh"

module apb_arbiter
   import boot_pkg::*;
(
   input  logic     cfg_done_i,
   input  apb_req_t cfg_req_i,
   input  apb_req_t nbf_req_i,
   output apb_rsp_t cfg_rsp_o,
   output apb_rsp_t nbf_rsp_o,
   output apb_req_t mem_req_o,
   output apb_req_t host_req_o,
   input  apb_rsp_t mem_rsp_i,
   input  apb_rsp_t host_rsp_i
);

   apb_req_t sel_req;
   apb_rsp_t sel_rsp;
   logic     to_host;

   // Config owns the bus until it is done since the loaders never overlap
   assign sel_req = cfg_done_i ? nbf_req_i : cfg_req_i;
   assign to_host = sel_req.paddr[`BOOT_HOST_BIT];

   always_comb
   begin
      mem_req_o         = sel_req;
      mem_req_o.psel    = sel_req.psel && !to_host;
      mem_req_o.penable = sel_req.penable && !to_host;

      host_req_o         = sel_req;
      host_req_o.psel    = sel_req.psel && to_host;
      host_req_o.penable = sel_req.penable && to_host;
   end

   assign sel_rsp = to_host ? host_rsp_i : mem_rsp_i;

   // Idle side sees an all-zero response
   always_comb
   begin
      cfg_rsp_o = '0;
      nbf_rsp_o = '0;
      if (cfg_done_i)
         nbf_rsp_o = sel_rsp;
      else
         cfg_rsp_o = sel_rsp;
   end

endmodule

`default_nettype wire

/* source/boot_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "boot_defs.svh"

module boot_mem
   import boot_pkg::*;
(
   input  logic     clk_i,
   input  apb_req_t apb_i,
   output apb_rsp_t apb_o
);

   data_t    mem_q [`BOOT_MEM_WORDS];
   mem_idx_t idx;
   logic     access;

   // Word index from bits 7..2 so upper address bits alias
   assign idx    = apb_i.paddr[`BOOT_MEM_IDX_W+1:2];
   assign access = apb_i.psel && apb_i.penable;

   always_ff @(posedge clk_i)
   begin
      if (access && apb_i.pwrite)
         mem_q[idx] <= apb_i.pwdata;
   end

   assign apb_o.pready = access;
   assign apb_o.prdata = mem_q[idx];

endmodule

`default_nettype wire

/* source/host_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "boot_defs.svh"

module host_regs
   import boot_pkg::*;
(
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  apb_req_t apb_i,
   output apb_rsp_t apb_o,
   output logic     freeze_o,
   output logic     program_finish_o
);

   logic [`BOOT_HOST_BIT-1:0] ofs;
   logic access;
   logic sel_freeze;
   logic sel_finish;
   logic freeze_q;
   logic finish_q;

   assign ofs        = apb_i.paddr[`BOOT_HOST_BIT-1:0];
   assign access     = apb_i.psel && apb_i.penable;
   assign sel_freeze = (ofs == `BOOT_FREEZE_OFS);
   assign sel_finish = (ofs == `BOOT_FINISH_OFS);

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         freeze_q <= 1'b1;
         finish_q <= 1'b0;
      end
      else if (access && apb_i.pwrite)
      begin
         if (sel_freeze)
            freeze_q <= apb_i.pwdata[0];
         // Sticky once set
         if (sel_finish)
            finish_q <= finish_q || apb_i.pwdata[0];
      end
   end

   always_comb
   begin
      apb_o.pready = access;
      apb_o.prdata = '0;
      if (sel_freeze)
         apb_o.prdata[0] = freeze_q;
      else if (sel_finish)
         apb_o.prdata[0] = finish_q;
   end

   assign freeze_o         = freeze_q;
   assign program_finish_o = finish_q;

endmodule

`default_nettype wire

/* source/boot_top.sv */
`timescale 1ns/1ps
`default_nettype none

module boot_top
   import boot_pkg::*;
(
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  nbf_rec_t rec_i,
   input  logic     rec_valid_i,
   output logic     rec_ready_o,
   output data_t    rsp_data_o,
   output logic     rsp_valid_o,
   output logic     freeze_o,
   output logic     program_finish_o
);

   apb_req_t cfg_req;
   apb_rsp_t cfg_rsp;
   apb_req_t nbf_req;
   apb_rsp_t nbf_rsp;
   apb_req_t mem_req;
   apb_rsp_t mem_rsp;
   apb_req_t host_req;
   apb_rsp_t host_rsp;
   logic     cfg_done;

   cfg_loader u_cfg_loader (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .apb_o    (cfg_req),
      .apb_i    (cfg_rsp),
      .done_o   (cfg_done)
   );

   // Program loading waits for the memory clear and unfreeze
   nbf_loader u_nbf_loader (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .enable_i    (cfg_done),
      .rec_i       (rec_i),
      .rec_valid_i (rec_valid_i),
      .rec_ready_o (rec_ready_o),
      .apb_o       (nbf_req),
      .apb_i       (nbf_rsp),
      .rsp_data_o  (rsp_data_o),
      .rsp_valid_o (rsp_valid_o)
   );

   apb_arbiter u_apb_arbiter (
      .cfg_done_i (cfg_done),
      .cfg_req_i  (cfg_req),
      .nbf_req_i  (nbf_req),
      .cfg_rsp_o  (cfg_rsp),
      .nbf_rsp_o  (nbf_rsp),
      .mem_req_o  (mem_req),
      .host_req_o (host_req),
      .mem_rsp_i  (mem_rsp),
      .host_rsp_i (host_rsp)
   );

   boot_mem u_boot_mem (
      .clk_i (clk_i),
      .apb_i (mem_req),
      .apb_o (mem_rsp)
   );

   host_regs u_host_regs (
      .clk_i            (clk_i),
      .arst_n_i         (arst_n_i),
      .apb_i            (host_req),
      .apb_o            (host_rsp),
      .freeze_o         (freeze_o),
      .program_finish_o (program_finish_o)
   );

endmodule

`default_nettype wire

/* test/boot_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module boot_chk (
   input logic clk_i,
   input logic arst_n_i,
   input logic freeze_i,
   input logic rec_ready_i,
   input logic rsp_valid_i,
   input logic program_finish_i
);

   a_freeze_at_start: assert property (@(posedge clk_i) $rose(arst_n_i) |-> freeze_i)
      else $error("freeze_o low in the first cycle after reset");

   // No records while the host still holds the system frozen
   a_no_ready_frozen: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(rec_ready_i && freeze_i))
      else $error("rec_ready_o high while freeze_o is high");

   a_rsp_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rsp_valid_i |=> !rsp_valid_i)
      else $error("rsp_valid_o held for two cycles");

   a_finish_sticky: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      program_finish_i |=> program_finish_i)
      else $error("program_finish_o fell after being set");

endmodule

bind boot_top boot_chk u_boot_chk (
   .clk_i            (clk_i),
   .arst_n_i         (arst_n_i),
   .freeze_i         (freeze_o),
   .rec_ready_i      (rec_ready_o),
   .rsp_valid_i      (rsp_valid_o),
   .program_finish_i (program_finish_o)
);

`default_nettype wire

/* test/boot_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module boot_tb
   import boot_pkg::*;
();

   localparam int max_recs = 32;

   logic     clk = 1'b0;
   logic     arst_n;
   nbf_rec_t rec;
   logic     rec_valid;
   logic     rec_ready;
   data_t    rsp_data;
   logic     rsp_valid;
   logic     freeze;
   logic     program_finish;

   // Four words per record
   logic [31:0] golden [4*max_recs];
   int          num_recs;
   int          num_reads = 0;
   int          rsp_seen = 0;
   logic        armed = 1'b0;

   boot_top DUT (
      .clk_i            (clk),
      .arst_n_i         (arst_n),
      .rec_i            (rec),
      .rec_valid_i      (rec_valid),
      .rec_ready_o      (rec_ready),
      .rsp_data_o       (rsp_data),
      .rsp_valid_o      (rsp_valid),
      .freeze_o         (freeze),
      .program_finish_o (program_finish)
   );

   always #2 clk = ~clk;

   always @(negedge clk)
      if (rsp_valid)
         rsp_seen <= rsp_seen + 1;

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected)
      begin
         $display("FAIL %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
         abort_run();
      end
   endtask

   task automatic send_record(input int n);
      nbf_rec_t r;
      int       cycles;
      r.op   = nbf_op_e'(golden[4*n][1:0]);
      r.addr = addr_t'(golden[4*n+1]);
      r.data = golden[4*n+2];
      @(posedge clk);
      rec       <= r;
      rec_valid <= 1'b1;
      @(negedge clk);
      while (!rec_ready)
         @(negedge clk);
      // Taken on this edge
      @(posedge clk);
      rec_valid <= 1'b0;
      if (r.op == NBF_READ)
      begin
         cycles = 0;
         @(negedge clk);
         while (!rsp_valid && cycles < 8)
         begin
            @(negedge clk);
            cycles++;
         end
         if (!rsp_valid)
         begin
            $display("No read response came back for record %0d", n);
            abort_run();
         end
         check_equal(rsp_data, golden[4*n+3], $sformatf("read data of record %0d", n));
      end
   endtask

   initial
   begin
      wait (armed);
      repeat (130 + num_recs * 10 + 100) @(posedge clk);
      $display("Timeout: the boot run did not complete in the expected time");
      abort_run();
   end

   initial
   begin
      int n;
      int cycles;
      void'($urandom(32'h213));
      arst_n    = 1'b0;
      rec       = '0;
      rec_valid = 1'b0;
      for (int i = 0; i < 4*max_recs; i++)
         golden[i] = '1;
      $readmemh("test/boot_golden.txt", golden);
      num_recs = 0;
      while (num_recs < max_recs && golden[4*num_recs] !== '1)
         num_recs++;
      armed = 1'b1;

      repeat (5) @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      check_equal(32'(freeze), 32'd1, "freeze after reset");
      check_equal(32'(program_finish), 32'd0, "program finish after reset");
      check_equal(32'(rec_ready), 32'd0, "record ready after reset");

      // Memory clear plus unfreeze takes 65 transfers of 2 cycles
      cycles = 0;
      while (freeze && cycles < 200)
      begin
         @(negedge clk);
         cycles++;
      end
      check_equal(cycles, 32'd130, "cycles from reset release to unfreeze");
      check_equal(32'(rec_ready), 32'd1, "record ready after unfreeze");

      for (n = 0; n < num_recs; n++)
      begin
         repeat ($urandom % 4) @(posedge clk);
         if (golden[4*n] == 32'd1)
            num_reads++;
         send_record(n);
      end

      cycles = 0;
      while (!program_finish && cycles < 8)
      begin
         @(negedge clk);
         cycles++;
      end
      check_equal(32'(program_finish), 32'd1, "program finish after finish record");
      repeat (20)
      begin
         @(negedge clk);
         check_equal(32'(rec_ready), 32'd0, "record ready after finish");
      end
      check_equal(rsp_seen, num_reads, "number of read responses");
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

/* test/boot_golden.txt */
// One record per line with opcode, address, data and expected read data in hex
// Opcode 0 is a write, 1 a read and 2 the finish record
1 0000 00000000 00000000
1 00fc 00000000 00000000
1 0080 00000000 00000000
0 0010 deadbeef 00000000
1 0010 00000000 deadbeef
0 0010 12345678 00000000
1 0010 00000000 12345678
1 0013 00000000 12345678
0 0024 a5a5a5a5 00000000
1 0124 00000000 a5a5a5a5
1 4024 00000000 a5a5a5a5
0 0100 cafef00d 00000000
1 0000 00000000 cafef00d
1 0014 00000000 00000000
1 8000 00000000 00000000
1 8004 00000000 00000000
1 8008 00000000 00000000
0 8008 ffffffff 00000000
1 8000 00000000 00000000
1 8004 00000000 00000000
2 0000 00000000 00000000

/* verilog.f */
+incdir+source
source/boot_pkg.sv
source/cfg_loader.sv
source/nbf_loader.sv
source/apb_arbiter.sv
source/boot_mem.sv
source/host_regs.sv
source/boot_top.sv
test/boot_chk.sv
test/boot_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module boot_tb -o boot_sim
./obj_dir/boot_sim | tee sim.log
if grep -qx "Simulation passed" sim.log; then
   echo "PASS"
else
   echo "FAIL"
   exit 1
fi
